// File: design/scope_acq.sv
// one scope acquisition channel with equalization, decimation and edge trigger
module scope_acq (
  // system
  input  logic                 clk,
  input  logic                 rstn,
  // adc stream, one sample per clock
  input  scope_pkg::sample_t   adc_dat,
  // static configuration
  input  scope_pkg::filt_cfg_t filt_cfg,
  input  scope_pkg::dec_cfg_t  dec_cfg,
  input  scope_pkg::trig_cfg_t trig_cfg,
  // decimated stream and trigger
  output scope_pkg::smp_t      smp,
  output logic                 trig
);
  import scope_pkg::*;

  ////////////////////////////////////////
  // internal stream
  ////////////////////////////////////////

  sample_t flt_dat;  // equalized, every clock

  ////////////////////////////////////////
  // equalization
  ////////////////////////////////////////

  // nine clocks from adc_dat
  scope_filter u_filter (
    .clk     (clk),
    .rstn    (rstn),
    .adc_dat (adc_dat),
    .cfg     (filt_cfg),
    .flt_dat (flt_dat)
  );

  ////////////////////////////////////////
  // decimation
  ////////////////////////////////////////

  // averages 2^shift samples, strobe per block
  scope_dec u_dec (
    .clk     (clk),
    .rstn    (rstn),
    .flt_dat (flt_dat),
    .cfg     (dec_cfg),
    .dec_smp (smp)
  );

  ////////////////////////////////////////
  // trigger
  ////////////////////////////////////////

  // watches the averaged stream seen at the output
  scope_trig u_trig (
    .clk  (clk),
    .rstn (rstn),
    .smp  (smp),
    .cfg  (trig_cfg),
    .trig (trig)
  );

endmodule

// File: design/scope_config.svh
// width settings shared by the acquisition channel of the scope front end
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

////////////////////////////////////////
// sample stream
////////////////////////////////////////

`define SCOPE_DW      14  // adc sample width

////////////////////////////////////////
// filter coefficients
////////////////////////////////////////

`define SCOPE_AW      18  // aa coefficient width
`define SCOPE_CW      25  // bb, kk and pp coefficient width

////////////////////////////////////////
// decimation
////////////////////////////////////////

`define SCOPE_DEC_SW  3   // shift field, ratio 1..128
`define SCOPE_DEC_MAX 7   // largest log2 ratio

`endif

// File: design/scope_dec.sv
// block averaging decimator with power of two ratio and sample strobe
`include "scope_config.svh"

module scope_dec (
  input  logic                clk,
  input  logic                rstn,
  input  scope_pkg::sample_t  flt_dat,
  input  scope_pkg::dec_cfg_t cfg,
  output scope_pkg::smp_t     dec_smp
);
  import scope_pkg::*;

  localparam int CNT_W = `SCOPE_DEC_MAX;             // counts up to 127
  localparam int ACC_W = `SCOPE_DW + `SCOPE_DEC_MAX;  // room for 128 samples

  ////////////////////////////////////////
  // block counter
  ////////////////////////////////////////

  logic [CNT_W-1:0] cnt;      // position inside block
  logic [CNT_W-1:0] cnt_end;  // 2^shift - 1
  logic             blk_end;

  // wraps to all ones for the largest shift
  assign cnt_end = (CNT_W'(1) << cfg.shift) - CNT_W'(1);
  assign blk_end = (cnt == cnt_end);

  ////////////////////////////////////////
  // accumulator
  ////////////////////////////////////////

  logic signed [ACC_W-1:0] acc;  // sum of earlier samples in block
  logic signed [ACC_W-1:0] sum;  // including current sample
  logic signed [ACC_W-1:0] avg;

  assign sum = acc + flt_dat;
  assign avg = sum >>> cfg.shift;  // floor average

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt     <= '0;
      acc     <= '0;
      dec_smp <= '0;
    end else begin
      dec_smp.vld <= blk_end;
      if (blk_end) begin
        cnt         <= '0;
        acc         <= '0;  // next block starts clean
        dec_smp.dat <= sample_t'(avg);
      end else begin
        cnt <= cnt + 1'b1;
        acc <= sum;
      end
    end
  end

  // ratio known and held static out of reset
  a_shift_static: assert property (@(posedge clk) disable iff (!rstn)
    !$isunknown(cfg.shift) && $stable(cfg.shift))
    else $error("decimation shift %0d unknown or changed while running", cfg.shift);

endmodule

// File: design/scope_filter.sv
// equalization filter that corrects the analog input chain of one scope channel
module scope_filter (
  input  logic                 clk,
  input  logic                 rstn,
  input  scope_pkg::sample_t   adc_dat,
  input  scope_pkg::filt_cfg_t cfg,
  output scope_pkg::sample_t   flt_dat
);
  import scope_pkg::*;

  // clip limits of the output code
  localparam sample_t SAT_MAX = {1'b0, {($bits(sample_t)-1){1'b1}}};
  localparam sample_t SAT_MIN = {1'b1, {($bits(sample_t)-1){1'b0}}};

  ////////////////////////////////////////
  // fir
  ////////////////////////////////////////

  logic signed [38:0] bb_mult;  // 14 x 25
  logic signed [32:0] r2_sum;
  logic signed [31:0] r01_reg;  // input scaled by 2^18
  logic signed [27:0] r02_reg;  // scaled product
  logic signed [32:0] r1_reg;
  logic signed [22:0] r2_reg;

  assign bb_mult = adc_dat * cfg.bb;
  assign r2_sum  = r01_reg + r1_reg;  // current x*2^18 plus delayed difference

  always_ff @(posedge clk) begin
    if (!rstn) begin
      r01_reg <= '0;
      r02_reg <= '0;
      r1_reg  <= '0;
      r2_reg  <= '0;
    end else begin
      r01_reg <= {adc_dat, 18'h0};
      r02_reg <= bb_mult[37:10];
      r1_reg  <= r02_reg - r01_reg;  // x*bb - x*2^18, one sample late
      r2_reg  <= r2_sum[32:10];
    end
  end

  ////////////////////////////////////////
  // iir 1
  ////////////////////////////////////////

  logic signed [40:0] aa_mult;  // 23 x 18
  logic signed [48:0] r3_sum;
  logic signed [22:0] r3_reg;

  assign aa_mult = r3_reg * cfg.aa;
  // y = x + y - y*aa, at 2^25 scale
  assign r3_sum  = $signed({r2_reg, 25'h0}) + $signed({r3_reg, 25'h0}) - aa_mult;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      r3_reg <= '0;
    end else begin
      r3_reg <= r3_sum[47:25];
    end
  end

  ////////////////////////////////////////
  // iir 2
  ////////////////////////////////////////

  logic signed [39:0] pp_mult;  // 15 x 25
  logic signed [14:0] r3_shr;   // upper 15 bits of iir 1
  logic signed [14:0] r4_sum;
  logic signed [14:0] r4_reg;

  assign pp_mult = r4_reg * cfg.pp;
  assign r4_sum  = r3_shr + $signed(pp_mult[30:16]);  // wraps at 15 bits

  always_ff @(posedge clk) begin
    if (!rstn) begin
      r3_shr <= '0;
      r4_reg <= '0;
    end else begin
      r3_shr <= r3_reg[22:8];
      r4_reg <= r4_sum;
    end
  end

  ////////////////////////////////////////
  // gain and saturation
  ////////////////////////////////////////

  logic signed [39:0] kk_mult;  // 15 x 25
  logic signed [14:0] kk_top;   // product at 2^-24, one guard bit
  logic signed [14:0] r4_reg_r;
  logic signed [14:0] r4_reg_rr;
  sample_t            r5_reg;

  assign kk_mult = r4_reg_rr * cfg.kk;
  assign kk_top  = kk_mult[38:24];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      r4_reg_r  <= '0;
      r4_reg_rr <= '0;
      r5_reg    <= '0;
    end else begin
      r4_reg_r  <= r4_reg;  // two delays to line up with the multiplier
      r4_reg_rr <= r4_reg_r;
      if (kk_top > SAT_MAX) begin
        r5_reg <= SAT_MAX;  // clip high
      end else if (kk_top < SAT_MIN) begin
        r5_reg <= SAT_MIN;  // clip low
      end else begin
        r5_reg <= kk_mult[37:24];
      end
    end
  end

  assign flt_dat = r5_reg;  // nine registers after adc_dat

  // output known on every clock out of reset
  a_flt_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(flt_dat))
    else $error("flt_dat unknown");

endmodule

// File: design/scope_pkg.sv
// shared types for the scope acquisition channel, samples and configuration
`include "scope_config.svh"

package scope_pkg;

  ////////////////////////////////////////
  // sample
  ////////////////////////////////////////

  typedef logic signed [`SCOPE_DW-1:0] sample_t;  // two's complement adc code

  ////////////////////////////////////////
  // configuration bundles
  ////////////////////////////////////////

  // equalization coefficients, all signed
  typedef struct packed {
    logic signed [`SCOPE_AW-1:0] aa;  // iir 1 pole
    logic signed [`SCOPE_CW-1:0] bb;  // fir tap
    logic signed [`SCOPE_CW-1:0] kk;  // output gain
    logic signed [`SCOPE_CW-1:0] pp;  // iir 2 pole
  } filt_cfg_t;

  typedef struct packed {
    logic [`SCOPE_DEC_SW-1:0] shift;  // log2 of averaging ratio
  } dec_cfg_t;

  typedef struct packed {
    logic    en;        // trigger enable
    logic    edge_sel;  // 0 rising, 1 falling
    sample_t level;     // crossing level
    sample_t hyst;      // arming distance from level
  } trig_cfg_t;

  ////////////////////////////////////////
  // decimated stream
  ////////////////////////////////////////

  typedef struct packed {
    sample_t dat;  // held between strobes
    logic    vld;  // one cycle per averaged sample
  } smp_t;

endpackage

// File: design/scope_trig.sv
// edge trigger with hysteresis arming on the decimated sample stream
module scope_trig (
  input  logic                 clk,
  input  logic                 rstn,
  input  scope_pkg::smp_t      smp,
  input  scope_pkg::trig_cfg_t cfg,
  output logic                 trig
);
  import scope_pkg::*;

  ////////////////////////////////////////
  // thresholds
  ////////////////////////////////////////

  // one extra bit so level +- hyst cannot wrap
  logic signed [$bits(sample_t):0] arm_lo;
  logic signed [$bits(sample_t):0] arm_hi;
  logic                            arm_ok;   // far enough on the arming side
  logic                            fire_ok;  // level reached
  logic                            armed;

  assign arm_lo = cfg.level - cfg.hyst;
  assign arm_hi = cfg.level + cfg.hyst;

  always_comb begin
    if (cfg.edge_sel) begin
      arm_ok  = (smp.dat >= arm_hi);     // falling, arm above
      fire_ok = (smp.dat <= cfg.level);
    end else begin
      arm_ok  = (smp.dat <= arm_lo);     // rising, arm below
      fire_ok = (smp.dat >= cfg.level);
    end
  end

  ////////////////////////////////////////
  // arm and fire
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      armed <= 1'b0;
      trig  <= 1'b0;
    end else begin
      trig <= 1'b0;  // pulse only
      if (!cfg.en) begin
        armed <= 1'b0;
      end else if (smp.vld) begin
        if (armed && fire_ok) begin
          trig  <= 1'b1;  // one clock after the firing strobe
          armed <= 1'b0;
        end else if (arm_ok) begin
          armed <= 1'b1;
        end
      end
    end
  end

  // firing disarms, so no back to back pulses
  a_trig_pulse: assert property (@(posedge clk) disable iff (!rstn) trig |=> !trig)
    else $error("trig high for two cycles");

endmodule

// File: scope_acq.f
+incdir+design
design/scope_pkg.sv
design/scope_filter.sv
design/scope_dec.sv
design/scope_trig.sv
design/scope_acq.sv
verification/tb_clk_gen.sv
verification/tb_scope_acq.sv

// File: verification/tb_clk_gen.sv
// free running clock for the scope channel testbench, period of 4
module tb_clk_gen (
  output logic clk
);

  localparam int HALF = 2;  // half period

  initial begin
    clk = 1'b0;  // first rising edge at 2
    forever begin
      #HALF clk = ~clk;
    end
  end

endmodule

// File: verification/tb_scope_acq.sv
// testbench for the scope acquisition channel, random stimulus against a cycle model
`include "scope_config.svh"

module tb_scope_acq;
  import scope_pkg::*;

  ////////////////////////////////////////
  // test lengths and limits
  ////////////////////////////////////////

  localparam int RST_CYC  = 5;
  localparam int LEN_UNIT = 300;
  localparam int LEN_SAT  = 400;
  localparam int LEN_DEC3 = 200;
  localparam int LEN_DEC7 = 640;   // five blocks of 128
  localparam int LEN_RISE = 1500;
  localparam int LEN_FALL = 1500;
  localparam int LEN_OFF  = 400;
  localparam int RUN_CYC  = LEN_UNIT + LEN_SAT + LEN_DEC3 + LEN_DEC7
                          + LEN_RISE + LEN_FALL + LEN_OFF + 7 * RST_CYC;
  localparam int MAX_CYC  = RUN_CYC + RUN_CYC / 10;  // 10% margin

  localparam int SMP_MAX  = (1 << (`SCOPE_DW - 1)) - 1;
  localparam int SMP_MIN  = -(1 << (`SCOPE_DW - 1));
  localparam int RAMP_TOP = 1200;  // ramp turns around here

  // stimulus kinds and test phases
  localparam int MODE_NOISE = 0;
  localparam int MODE_RAMP  = 1;
  localparam int PH_UNIT = 0;
  localparam int PH_SAT  = 1;
  localparam int PH_DEC  = 2;
  localparam int PH_TRIG = 3;
  localparam int PH_OFF  = 4;

  logic      clk;
  logic      rstn;
  sample_t   adc_dat;
  filt_cfg_t filt_cfg;
  dec_cfg_t  dec_cfg;
  trig_cfg_t trig_cfg;
  smp_t      smp;
  logic      trig;

  integer    seed;
  int        cycles;
  int        phase;
  int        ramp;
  int        ramp_dir;
  int        gap;       // clocks since last strobe
  int        n_trig;
  int        n_sat_hi;
  int        n_sat_lo;
  filt_cfg_t fc_unit;
  filt_cfg_t fc_rand;
  dec_cfg_t  dc;
  trig_cfg_t tc;

  tb_clk_gen u_clk_gen (.clk(clk));

  scope_acq u_scope_acq (
    .clk      (clk),
    .rstn     (rstn),
    .adc_dat  (adc_dat),
    .filt_cfg (filt_cfg),
    .dec_cfg  (dec_cfg),
    .trig_cfg (trig_cfg),
    .smp      (smp),
    .trig     (trig)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  longint m_r01, m_r02, m_r1, m_r2, m_r3;  // fir and iir 1
  longint m_r3_shr, m_r4, m_r4_r, m_r4_rr, m_r5;
  int     m_cnt;
  longint m_acc;
  smp_t   m_smp;
  logic   m_armed;
  logic   m_trig;

  // keep the low bits, sign extended
  function automatic longint sext(input longint val, input int bits);
    longint tmp;
    tmp = val <<< (64 - bits);
    return tmp >>> (64 - bits);
  endfunction

  // one clock of the channel, later stages first so each reads old state
  task automatic model_step();
    longint prod;
    longint top;
    longint sum;
    longint lvl;
    longint hys;
    longint dat;
    logic   arm_ok;
    logic   fire_ok;
    if (!rstn) begin
      {m_r01, m_r02, m_r1, m_r2, m_r3} = '0;
      {m_r3_shr, m_r4, m_r4_r, m_r4_rr, m_r5} = '0;
      m_cnt   = 0;
      m_acc   = 0;
      m_smp   = '0;
      m_armed = 1'b0;
      m_trig  = 1'b0;
    end else begin
      // trigger on the current decimated sample
      lvl = sext(trig_cfg.level, `SCOPE_DW);
      hys = sext(trig_cfg.hyst, `SCOPE_DW);
      dat = sext(m_smp.dat, `SCOPE_DW);
      arm_ok  = trig_cfg.edge_sel ? (dat >= lvl + hys) : (dat <= lvl - hys);
      fire_ok = trig_cfg.edge_sel ? (dat <= lvl) : (dat >= lvl);
      m_trig = 1'b0;
      if (!trig_cfg.en) begin
        m_armed = 1'b0;
      end else if (m_smp.vld) begin
        if (m_armed && fire_ok) begin
          m_trig  = 1'b1;
          m_armed = 1'b0;
        end else if (arm_ok) begin
          m_armed = 1'b1;
        end
      end
      // block average, floor by arithmetic shift
      sum = m_acc + m_r5;
      if (m_cnt == (1 << dec_cfg.shift) - 1) begin
        m_smp.vld = 1'b1;
        m_smp.dat = sample_t'(sum >>> dec_cfg.shift);
        m_cnt     = 0;
        m_acc     = 0;
      end else begin
        m_smp.vld = 1'b0;
        m_cnt     = m_cnt + 1;
        m_acc     = sum;
      end
      // gain with clipping
      prod = m_r4_rr * sext(filt_cfg.kk, 25);
      top  = sext(prod >>> 24, 15);
      if (top > SMP_MAX) m_r5 = SMP_MAX;
      else if (top < SMP_MIN) m_r5 = SMP_MIN;
      else m_r5 = sext(prod >>> 24, 14);
      m_r4_rr = m_r4_r;
      m_r4_r  = m_r4;
      // iir 2, wraps at 15 bits
      prod     = m_r4 * sext(filt_cfg.pp, 25);
      m_r4     = sext(m_r3_shr + sext(prod >>> 16, 15), 15);
      m_r3_shr = sext(m_r3 >>> 8, 15);
      // iir 1 at 2^25 scale
      prod = m_r3 * sext(filt_cfg.aa, 18);
      m_r3 = sext((((m_r2 + m_r3) <<< 25) - prod) >>> 25, 23);
      // fir difference
      m_r2  = sext((m_r01 + m_r1) >>> 10, 23);
      m_r1  = sext(m_r02 - m_r01, 33);
      prod  = sext(adc_dat, `SCOPE_DW) * sext(filt_cfg.bb, 25);
      m_r02 = sext(prod >>> 10, 28);
      m_r01 = sext(sext(adc_dat, `SCOPE_DW) <<< 18, 32);
    end
  endtask

  always @(posedge clk) begin
    model_step();
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_smp(input smp_t exp, input smp_t act);
    if (act !== exp) begin
      $display("Fail smp: expected dat %h vld %h, actual dat %h vld %h",
               exp.dat, exp.vld, act.dat, act.vld);
      abort_run();
    end
  endtask

  task automatic check_trig(input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail trig: expected %h, actual %h", exp, act);
      abort_run();
    end
  endtask

  // runs on every falling edge, outputs settled
  task automatic watch_outputs();
    check_smp(m_smp, smp);
    check_trig(m_trig, trig);
    if (rstn) begin
      if (phase == PH_UNIT && smp.vld !== 1'b1) fail_now("no strobe on a clock with shift 0");
      if (smp.vld) begin
        if (gap != (1 << dec_cfg.shift)) fail_now("decimator strobe spacing is wrong");
        gap = 0;
      end
      gap = gap + 1;
      if (phase == PH_SAT && smp.dat == sample_t'(SMP_MAX)) n_sat_hi = n_sat_hi + 1;
      if (phase == PH_SAT && smp.dat == sample_t'(SMP_MIN)) n_sat_lo = n_sat_lo + 1;
      if (trig) n_trig = n_trig + 1;
      if (phase == PH_OFF && trig !== 1'b0) fail_now("trigger fired while disabled");
    end
  endtask

  // timeout
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYC) begin
      $display("run exceeded %0d cycles without finishing", MAX_CYC);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic drive_sample(input int mode);
    int step;
    if (mode == MODE_RAMP) begin
      step = ($random(seed) & 31) - 8;  // slow slope, small back steps near the level
      ramp = ramp + ramp_dir * step;
      if (ramp >= RAMP_TOP) ramp_dir = -1;
      else if (ramp <= -RAMP_TOP) ramp_dir = 1;
      adc_dat = sample_t'(ramp);
    end else begin
      adc_dat = sample_t'($random(seed));  // full scale
    end
  endtask

  // config only changes with rstn low
  task automatic run_test(input int mode, input int len, input filt_cfg_t fc,
                          input dec_cfg_t dcfg, input trig_cfg_t tcfg);
    rstn     = 1'b0;
    filt_cfg = fc;
    dec_cfg  = dcfg;
    trig_cfg = tcfg;
    adc_dat  = '0;
    ramp     = -RAMP_TOP;  // start on the rising arm side
    ramp_dir = 1;
    gap      = 1;
    repeat (RST_CYC) begin
      @(negedge clk);
      watch_outputs();
    end
    rstn = 1'b1;
    drive_sample(mode);
    repeat (len) begin
      @(negedge clk);
      watch_outputs();
      drive_sample(mode);
    end
  endtask

  initial begin
    seed     = 32'h079a79b2;
    cycles   = 0;
    n_sat_hi = 0;
    n_sat_lo = 0;
    n_trig   = 0;
    rstn     = 1'b0;
    adc_dat  = '0;
    filt_cfg = '0;
    dec_cfg  = '0;
    trig_cfg = '0;
    // bypass coefficients, fir and iir 1 cancel
    fc_unit.aa = '0;
    fc_unit.bb = '0;
    fc_unit.kk = 25'h0ffffff;
    fc_unit.pp = '0;
    dc.shift   = '0;
    tc         = '0;

    phase = PH_UNIT;
    run_test(MODE_NOISE, LEN_UNIT, fc_unit, dc, tc);

    // gain between 0.75 and 1 so the wrapped iir 2 clips both ways
    fc_rand.aa = $random(seed);
    fc_rand.bb = $random(seed);
    fc_rand.pp = $random(seed);
    fc_rand.kk = 25'h0c00000 | ($random(seed) & 25'h03fffff);
    phase = PH_SAT;
    run_test(MODE_NOISE, LEN_SAT, fc_rand, dc, tc);
    if (n_sat_hi == 0 || n_sat_lo == 0) fail_now("gain stage did not clip at both limits");

    phase    = PH_DEC;
    dc.shift = 3;
    run_test(MODE_NOISE, LEN_DEC3, fc_unit, dc, tc);
    dc.shift = 7;
    run_test(MODE_NOISE, LEN_DEC7, fc_unit, dc, tc);

    ////////////////////////////////////////
    // trigger on the ramp
    ////////////////////////////////////////

    phase       = PH_TRIG;
    dc.shift    = 2;
    tc.en       = 1'b1;
    tc.edge_sel = 1'b0;
    tc.level    = 600;
    tc.hyst     = 300;
    n_trig      = 0;
    run_test(MODE_RAMP, LEN_RISE, fc_unit, dc, tc);
    if (n_trig < 2) fail_now("rising edge trigger fired fewer than two times");

    tc.edge_sel = 1'b1;  // arms above 900
    n_trig      = 0;
    run_test(MODE_RAMP, LEN_FALL, fc_unit, dc, tc);
    if (n_trig < 2) fail_now("falling edge trigger fired fewer than two times");

    phase       = PH_OFF;
    tc.en       = 1'b0;
    tc.edge_sel = 1'b0;
    run_test(MODE_RAMP, LEN_OFF, fc_unit, dc, tc);

    $display("Testbench passed");
    $finish;
  end

endmodule
